/* Makefile */
TOOL     = verilator
TOP      = spi_tb
FILELIST = sim.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation PASS"; \
	else \
	  echo "simulation FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim.f */
spi_cmd_pkg.sv
spi_cfg_pkg.sv
spi_apb_regs.sv
spi_offload.sv
spi_engine_interconnect.sv
spi_engine_execution.sv
spi_subsystem_top.sv
spi_tb.sv

/* spi_apb_regs.sv */
// SPI register block
// Turns APB accesses into command, SDO and sync stream traffic and
// holds the offload configuration and its last result

module spi_apb_regs #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  spi_cfg_pkg::apb_req_t      apb_req,
  output spi_cfg_pkg::apb_rsp_t      apb_rsp,
  output spi_cmd_pkg::cmd_stream_t   cmd,
  input  logic                       cmd_ready,
  output logic                       sdo_valid,
  input  logic                       sdo_ready,
  output logic [DATA_WIDTH-1:0]      sdo_data,
  input  logic                       sdi_valid,
  output logic                       sdi_ready,
  input  logic [DATA_WIDTH-1:0]      sdi_data,
  input  spi_cmd_pkg::sync_stream_t  sync,
  output logic                       sync_ready,
  output spi_cfg_pkg::offload_cfg_t  offload_cfg,
  input  logic                       offload_result_valid,
  input  logic [DATA_WIDTH-1:0]      offload_result
);
  import spi_cmd_pkg::*;
  import spi_cfg_pkg::*;

  logic                  access;
  logic                  wr_access;
  logic                  rd_access;
  logic                  stall;
  logic                  addr_known;
  apb_data_t             rd_data;
  cmd_stream_t           cmd_q;
  logic                  sdo_valid_q;
  logic [DATA_WIDTH-1:0] sdo_data_q;
  sync_id_t              last_sync_q;
  logic                  offload_en_q;
  apb_data_t             offload_sdo_q;
  logic                  result_valid_q;
  logic [DATA_WIDTH-1:0] result_q;

  // Access phase of an APB transfer
  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;
  assign rd_access = access && !apb_req.pwrite;

  // ******************************
  // Address decode and read mux
  // ******************************

  always_comb begin
    addr_known = 1'b1;
    stall      = 1'b0;
    rd_data    = '0;
    case (apb_req.paddr)
      // Stream writes wait while the holding register is still full
      REG_CMD: stall = apb_req.pwrite && cmd_q.valid;
      REG_SDO: stall = apb_req.pwrite && sdo_valid_q;
      REG_SDI: begin
        stall   = !apb_req.pwrite && !sdi_valid;
        rd_data = apb_data_t'(sdi_data);
      end
      REG_SYNC:         rd_data = apb_data_t'(last_sync_q);
      REG_OFFLOAD_CTRL: rd_data = apb_data_t'(offload_en_q);
      REG_OFFLOAD_SDO:  rd_data = offload_sdo_q;
      REG_OFFLOAD_RESULT: begin
        rd_data     = apb_data_t'(result_q);
        // The valid flag sits in the top bit
        rd_data[31] = result_valid_q;
      end
      default: addr_known = 1'b0;
    endcase
  end

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = !(access && stall);
  assign apb_rsp.pslverr = access && !addr_known;

  // ******************************
  // Stream holding registers
  // ******************************

  // One-entry command buffer, loaded only when empty
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cmd_q.valid <= 1'b0;
    end else if (wr_access && apb_req.paddr == REG_CMD && !cmd_q.valid) begin
      cmd_q.valid <= 1'b1;
      cmd_q.data  <= cmd_word_t'(apb_req.pwdata[15:0]);
    end else if (cmd_ready) begin
      cmd_q.valid <= 1'b0;
    end
  end

  // One-entry SDO buffer, same rule as the command buffer
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sdo_valid_q <= 1'b0;
    end else if (wr_access && apb_req.paddr == REG_SDO && !sdo_valid_q) begin
      sdo_valid_q <= 1'b1;
      sdo_data_q  <= apb_req.pwdata[DATA_WIDTH-1:0];
    end else if (sdo_ready) begin
      sdo_valid_q <= 1'b0;
    end
  end

  assign cmd       = cmd_q;
  assign sdo_valid = sdo_valid_q;
  assign sdo_data  = sdo_data_q;

  // A REG_SDI read pulls one word and completes on that handshake
  assign sdi_ready = rd_access && apb_req.paddr == REG_SDI;

  // Syncs are always taken, only host ids are kept
  assign sync_ready = 1'b1;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      last_sync_q <= '0;
    end else if (sync.valid && sync.id != OFFLOAD_SYNC_ID) begin
      last_sync_q <= sync.id;
    end
  end

  // ******************************
  // Offload configuration and result
  // ******************************

  always_ff @(posedge clk) begin
    if (!resetn) begin
      offload_en_q <= 1'b0;
    end else if (wr_access && apb_req.paddr == REG_OFFLOAD_CTRL) begin
      offload_en_q <= apb_req.pwdata[0];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_access && apb_req.paddr == REG_OFFLOAD_SDO) begin
      offload_sdo_q <= apb_req.pwdata;
    end
  end

  assign offload_cfg.enable   = offload_en_q;
  assign offload_cfg.sdo_word = offload_sdo_q;

  // A new result wins over a clearing read in the same cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      result_valid_q <= 1'b0;
    end else if (offload_result_valid) begin
      result_valid_q <= 1'b1;
    end else if (rd_access && apb_req.paddr == REG_OFFLOAD_RESULT) begin
      result_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (offload_result_valid) begin
      result_q <= offload_result;
    end
  end

endmodule

/* spi_cfg_pkg.sv */
// SPI subsystem host-side definitions
// APB request and response, register map and offload configuration

package spi_cfg_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Register map of the host interface
  typedef enum apb_addr_t {
    REG_CMD            = 8'h00,
    REG_SDO            = 8'h04,
    REG_SDI            = 8'h08,
    REG_SYNC           = 8'h0c,
    REG_OFFLOAD_CTRL   = 8'h10,
    REG_OFFLOAD_SDO    = 8'h14,
    REG_OFFLOAD_RESULT = 8'h18
  } reg_addr_e;

  // Offload setup as programmed by the host
  typedef struct packed {
    logic      enable;
    apb_data_t sdo_word;
  } offload_cfg_t;

endpackage

/* spi_cmd_pkg.sv */
// SPI engine command definitions
// Command word layout, opcodes and the command and sync stream structs

package spi_cmd_pkg;

  // One command word as it travels from a source to the engine
  typedef logic [15:0] cmd_word_t;

  // Sync identifier returned by the engine
  typedef logic [7:0] sync_id_t;

  // Opcode in bits 15 to 12 of a command word
  typedef enum logic [3:0] {
    OP_TRANSFER = 4'h0,
    OP_CS       = 4'h1,
    OP_SYNC     = 4'h2
  } cmd_op_e;

  // Command channel, ready runs separately against the flow
  typedef struct packed {
    logic      valid;
    cmd_word_t data;
  } cmd_stream_t;

  // Sync channel from the engine back to its source
  typedef struct packed {
    logic     valid;
    sync_id_t id;
  } sync_stream_t;

  // Sync id reserved for the offload sequence
  localparam sync_id_t OFFLOAD_SYNC_ID = 8'hff;

endpackage

/* spi_engine_execution.sv */
// SPI engine execution unit
// Decodes commands and shifts words in SPI mode 0 with one chip select

module spi_engine_execution #(
  parameter int DATA_WIDTH = 8,
  parameter int CLK_DIV    = 2
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  spi_cmd_pkg::cmd_stream_t   cmd,
  output logic                       cmd_ready,
  input  logic                       sdo_valid,
  output logic                       sdo_ready,
  input  logic [DATA_WIDTH-1:0]      sdo_data,
  output logic                       sdi_valid,
  input  logic                       sdi_ready,
  output logic [DATA_WIDTH-1:0]      sdi_data,
  output spi_cmd_pkg::sync_stream_t  sync,
  input  logic                       sync_ready,
  output logic                       cs_n,
  output logic                       sclk,
  output logic                       sdo,
  input  logic                       sdi
);
  import spi_cmd_pkg::*;

  localparam int BIT_W = $clog2(DATA_WIDTH);
  localparam int DIV_W = $clog2(2 * CLK_DIV);

  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_SDO,
    ST_SHIFT,
    ST_SDI,
    ST_SYNC
  } state_e;

  state_e           state;
  state_e           next_word;
  cmd_op_e          op;
  logic             wr_flag;
  logic             rd_flag;
  logic [7:0]       word_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic [DIV_W-1:0] div_cnt;
  data_t            tx_q;
  data_t            rx_q;
  sync_id_t         sync_id_q;
  logic             cs_n_q;
  logic             sclk_q;

  assign op = cmd_op_e'(cmd.data[15:12]);

  // Where to go once a word is done
  assign next_word = (word_cnt == 8'd0) ? ST_IDLE : (wr_flag ? ST_WAIT_SDO : ST_SHIFT);

  assign cmd_ready  = state == ST_IDLE;
  assign sdo_ready  = state == ST_WAIT_SDO;
  assign sdi_valid  = state == ST_SDI;
  assign sdi_data   = rx_q;
  assign sync.valid = state == ST_SYNC;
  assign sync.id    = sync_id_q;
  assign cs_n       = cs_n_q;
  assign sclk       = sclk_q;
  // MSB first, low outside a shift
  assign sdo        = (state == ST_SHIFT) && tx_q[DATA_WIDTH-1];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= ST_IDLE;
      cs_n_q   <= 1'b1;
      sclk_q   <= 1'b0;
      wr_flag  <= 1'b0;
      rd_flag  <= 1'b0;
      word_cnt <= '0;
      bit_cnt  <= '0;
      div_cnt  <= '0;
    end else begin
      case (state)
        // ******************************
        // Command decode
        // ******************************
        ST_IDLE: begin
          if (cmd.valid) begin
            case (op)
              // Chip select completes in the accepting cycle
              OP_CS: cs_n_q <= !cmd.data[0];
              OP_SYNC: begin
                sync_id_q <= cmd.data[7:0];
                state     <= ST_SYNC;
              end
              OP_TRANSFER: begin
                wr_flag  <= cmd.data[9];
                rd_flag  <= cmd.data[8];
                word_cnt <= cmd.data[7:0];
                bit_cnt  <= '0;
                div_cnt  <= '0;
                tx_q     <= '0;
                state    <= cmd.data[9] ? ST_WAIT_SDO : ST_SHIFT;
              end
              default: ;
            endcase
          end
        end
        ST_WAIT_SDO: begin
          if (sdo_valid) begin
            tx_q  <= sdo_data;
            state <= ST_SHIFT;
          end
        end
        // ******************************
        // Bit timing
        // ******************************
        ST_SHIFT: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == DIV_W'(CLK_DIV - 1)) begin
            // Rising sclk edge samples sdi
            sclk_q <= 1'b1;
            rx_q   <= {rx_q[DATA_WIDTH-2:0], sdi};
          end else if (div_cnt == DIV_W'(2 * CLK_DIV - 1)) begin
            sclk_q  <= 1'b0;
            div_cnt <= '0;
            tx_q    <= {tx_q[DATA_WIDTH-2:0], 1'b0};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(DATA_WIDTH - 1)) begin
              bit_cnt <= '0;
              if (rd_flag) begin
                state <= ST_SDI;
              end else begin
                state <= next_word;
                if (word_cnt != 8'd0) word_cnt <= word_cnt - 1'b1;
              end
            end
          end
        end
        // Stalls with sclk low until the word is taken
        ST_SDI: begin
          if (sdi_ready) begin
            state <= next_word;
            if (word_cnt != 8'd0) word_cnt <= word_cnt - 1'b1;
          end
        end
        ST_SYNC: if (sync_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* spi_engine_interconnect.sv */
// SPI engine interconnect
// Grants the engine to one source from its first command until a sync

module spi_engine_interconnect #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  spi_cmd_pkg::cmd_stream_t   s0_cmd,
  output logic                       s0_cmd_ready,
  input  logic                       s0_sdo_valid,
  output logic                       s0_sdo_ready,
  input  logic [DATA_WIDTH-1:0]      s0_sdo_data,
  output logic                       s0_sdi_valid,
  input  logic                       s0_sdi_ready,
  output logic [DATA_WIDTH-1:0]      s0_sdi_data,
  output spi_cmd_pkg::sync_stream_t  s0_sync,
  input  logic                       s0_sync_ready,
  input  spi_cmd_pkg::cmd_stream_t   s1_cmd,
  output logic                       s1_cmd_ready,
  input  logic                       s1_sdo_valid,
  output logic                       s1_sdo_ready,
  input  logic [DATA_WIDTH-1:0]      s1_sdo_data,
  output logic                       s1_sdi_valid,
  input  logic                       s1_sdi_ready,
  output logic [DATA_WIDTH-1:0]      s1_sdi_data,
  output spi_cmd_pkg::sync_stream_t  s1_sync,
  input  logic                       s1_sync_ready,
  output spi_cmd_pkg::cmd_stream_t   m_cmd,
  input  logic                       m_cmd_ready,
  output logic                       m_sdo_valid,
  input  logic                       m_sdo_ready,
  output logic [DATA_WIDTH-1:0]      m_sdo_data,
  input  logic                       m_sdi_valid,
  output logic                       m_sdi_ready,
  input  logic [DATA_WIDTH-1:0]      m_sdi_data,
  input  spi_cmd_pkg::sync_stream_t  m_sync,
  output logic                       m_sync_ready
);

  // Idle flag and owner folded into one state
  typedef enum logic [1:0] {
    IC_IDLE,
    IC_S0,
    IC_S1
  } owner_e;

  owner_e state;
  logic   own0;
  logic   own1;

  assign own0 = state == IC_S0;
  assign own1 = state == IC_S1;

  // Owner's command and SDO pass straight through to the engine
  assign m_cmd.data   = own1 ? s1_cmd.data : s0_cmd.data;
  assign m_cmd.valid  = (own0 && s0_cmd.valid) || (own1 && s1_cmd.valid);
  assign s0_cmd_ready = own0 && m_cmd_ready;
  assign s1_cmd_ready = own1 && m_cmd_ready;

  assign m_sdo_data   = own1 ? s1_sdo_data : s0_sdo_data;
  assign m_sdo_valid  = (own0 && s0_sdo_valid) || (own1 && s1_sdo_valid);
  assign s0_sdo_ready = own0 && m_sdo_ready;
  assign s1_sdo_ready = own1 && m_sdo_ready;

  // Return data goes to both, only the owner sees it valid
  assign s0_sdi_data  = m_sdi_data;
  assign s1_sdi_data  = m_sdi_data;
  assign s0_sdi_valid = own0 && m_sdi_valid;
  assign s1_sdi_valid = own1 && m_sdi_valid;
  assign m_sdi_ready  = (own0 && s0_sdi_ready) || (own1 && s1_sdi_ready);

  assign s0_sync.id    = m_sync.id;
  assign s1_sync.id    = m_sync.id;
  assign s0_sync.valid = own0 && m_sync.valid;
  assign s1_sync.valid = own1 && m_sync.valid;
  assign m_sync_ready  = (own0 && s0_sync_ready) || (own1 && s1_sync_ready);

  // Grant on the first command, s0 first, release after the sync handshake
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= IC_IDLE;
    end else if (state == IC_IDLE) begin
      if (s0_cmd.valid) begin
        state <= IC_S0;
      end else if (s1_cmd.valid) begin
        state <= IC_S1;
      end
    end else if (m_sync.valid && m_sync_ready) begin
      state <= IC_IDLE;
    end
  end

endmodule

/* spi_offload.sv */
// SPI offload sequencer
// On a trigger runs chip select, one read/write word, release and sync

module spi_offload #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       trigger,
  input  spi_cfg_pkg::offload_cfg_t  cfg,
  output spi_cmd_pkg::cmd_stream_t   cmd,
  input  logic                       cmd_ready,
  output logic                       sdo_valid,
  input  logic                       sdo_ready,
  output logic [DATA_WIDTH-1:0]      sdo_data,
  input  logic                       sdi_valid,
  output logic                       sdi_ready,
  input  logic [DATA_WIDTH-1:0]      sdi_data,
  input  spi_cmd_pkg::sync_stream_t  sync,
  output logic                       sync_ready,
  output logic                       result_valid,
  output logic [DATA_WIDTH-1:0]      result
);
  import spi_cmd_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CS_ON,
    ST_XFER,
    ST_SDO,
    ST_SDI,
    ST_CS_OFF,
    ST_SYNC_CMD,
    ST_SYNC_WAIT
  } state_e;

  state_e                state;
  logic [DATA_WIDTH-1:0] result_q;

  // Command word for each command-issuing state
  always_comb begin
    cmd.valid = 1'b0;
    cmd.data  = '0;
    case (state)
      ST_CS_ON: begin
        cmd.valid = 1'b1;
        cmd.data  = {OP_CS, 11'd0, 1'b1};
      end
      // Single word with both write and read flags
      ST_XFER: begin
        cmd.valid = 1'b1;
        cmd.data  = {OP_TRANSFER, 2'b00, 1'b1, 1'b1, 8'd0};
      end
      ST_CS_OFF: begin
        cmd.valid = 1'b1;
        cmd.data  = {OP_CS, 12'd0};
      end
      ST_SYNC_CMD: begin
        cmd.valid = 1'b1;
        cmd.data  = {OP_SYNC, 4'd0, OFFLOAD_SYNC_ID};
      end
      default: ;
    endcase
  end

  assign sdo_valid  = state == ST_SDO;
  assign sdo_data   = cfg.sdo_word[DATA_WIDTH-1:0];
  assign sdi_ready  = state == ST_SDI;
  assign sync_ready = state == ST_SYNC_WAIT;
  assign result     = result_q;

  // Sequence steps advance on the handshake of their own channel
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= ST_IDLE;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      case (state)
        // Triggers while a run is in progress are dropped
        ST_IDLE:     if (trigger && cfg.enable) state <= ST_CS_ON;
        ST_CS_ON:    if (cmd_ready) state <= ST_XFER;
        ST_XFER:     if (cmd_ready) state <= ST_SDO;
        ST_SDO:      if (sdo_ready) state <= ST_SDI;
        ST_SDI:      if (sdi_valid) state <= ST_CS_OFF;
        ST_CS_OFF:   if (cmd_ready) state <= ST_SYNC_CMD;
        ST_SYNC_CMD: if (cmd_ready) state <= ST_SYNC_WAIT;
        ST_SYNC_WAIT: begin
          if (sync.valid) begin
            state        <= ST_IDLE;
            result_valid <= sync.id == OFFLOAD_SYNC_ID;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Received word, kept until the next run
  always_ff @(posedge clk) begin
    if (state == ST_SDI && sdi_valid) begin
      result_q <= sdi_data;
    end
  end

endmodule

/* spi_subsystem_top.sv */
// SPI subsystem top level
// Register block and offload share one execution engine through the interconnect

module spi_subsystem_top #(
  parameter int DATA_WIDTH = 8,
  parameter int CLK_DIV    = 2
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  spi_cfg_pkg::apb_req_t  apb_req,
  output spi_cfg_pkg::apb_rsp_t  apb_rsp,
  input  logic                   trigger,
  output logic                   cs_n,
  output logic                   sclk,
  output logic                   sdo,
  input  logic                   sdi
);
  import spi_cmd_pkg::*;
  import spi_cfg_pkg::*;

  // Register block side of the interconnect
  cmd_stream_t           s0_cmd;
  logic                  s0_cmd_ready;
  logic                  s0_sdo_valid;
  logic                  s0_sdo_ready;
  logic [DATA_WIDTH-1:0] s0_sdo_data;
  logic                  s0_sdi_valid;
  logic                  s0_sdi_ready;
  logic [DATA_WIDTH-1:0] s0_sdi_data;
  sync_stream_t          s0_sync;
  logic                  s0_sync_ready;

  // Offload side of the interconnect
  cmd_stream_t           s1_cmd;
  logic                  s1_cmd_ready;
  logic                  s1_sdo_valid;
  logic                  s1_sdo_ready;
  logic [DATA_WIDTH-1:0] s1_sdo_data;
  logic                  s1_sdi_valid;
  logic                  s1_sdi_ready;
  logic [DATA_WIDTH-1:0] s1_sdi_data;
  sync_stream_t          s1_sync;
  logic                  s1_sync_ready;

  // Engine side
  cmd_stream_t           m_cmd;
  logic                  m_cmd_ready;
  logic                  m_sdo_valid;
  logic                  m_sdo_ready;
  logic [DATA_WIDTH-1:0] m_sdo_data;
  logic                  m_sdi_valid;
  logic                  m_sdi_ready;
  logic [DATA_WIDTH-1:0] m_sdi_data;
  sync_stream_t          m_sync;
  logic                  m_sync_ready;

  offload_cfg_t          offload_cfg;
  logic                  offload_result_valid;
  logic [DATA_WIDTH-1:0] offload_result;

  spi_apb_regs #(.DATA_WIDTH(DATA_WIDTH)) u_regs (
    .clk(clk), .resetn(resetn), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .cmd(s0_cmd), .cmd_ready(s0_cmd_ready),
    .sdo_valid(s0_sdo_valid), .sdo_ready(s0_sdo_ready), .sdo_data(s0_sdo_data),
    .sdi_valid(s0_sdi_valid), .sdi_ready(s0_sdi_ready), .sdi_data(s0_sdi_data),
    .sync(s0_sync), .sync_ready(s0_sync_ready), .offload_cfg(offload_cfg),
    .offload_result_valid(offload_result_valid), .offload_result(offload_result)
  );

  spi_offload #(.DATA_WIDTH(DATA_WIDTH)) u_offload (
    .clk(clk), .resetn(resetn), .trigger(trigger), .cfg(offload_cfg),
    .cmd(s1_cmd), .cmd_ready(s1_cmd_ready),
    .sdo_valid(s1_sdo_valid), .sdo_ready(s1_sdo_ready), .sdo_data(s1_sdo_data),
    .sdi_valid(s1_sdi_valid), .sdi_ready(s1_sdi_ready), .sdi_data(s1_sdi_data),
    .sync(s1_sync), .sync_ready(s1_sync_ready),
    .result_valid(offload_result_valid), .result(offload_result)
  );

  spi_engine_interconnect #(.DATA_WIDTH(DATA_WIDTH)) u_interconnect (
    .clk(clk), .resetn(resetn),
    .s0_cmd(s0_cmd), .s0_cmd_ready(s0_cmd_ready),
    .s0_sdo_valid(s0_sdo_valid), .s0_sdo_ready(s0_sdo_ready), .s0_sdo_data(s0_sdo_data),
    .s0_sdi_valid(s0_sdi_valid), .s0_sdi_ready(s0_sdi_ready), .s0_sdi_data(s0_sdi_data),
    .s0_sync(s0_sync), .s0_sync_ready(s0_sync_ready),
    .s1_cmd(s1_cmd), .s1_cmd_ready(s1_cmd_ready),
    .s1_sdo_valid(s1_sdo_valid), .s1_sdo_ready(s1_sdo_ready), .s1_sdo_data(s1_sdo_data),
    .s1_sdi_valid(s1_sdi_valid), .s1_sdi_ready(s1_sdi_ready), .s1_sdi_data(s1_sdi_data),
    .s1_sync(s1_sync), .s1_sync_ready(s1_sync_ready),
    .m_cmd(m_cmd), .m_cmd_ready(m_cmd_ready),
    .m_sdo_valid(m_sdo_valid), .m_sdo_ready(m_sdo_ready), .m_sdo_data(m_sdo_data),
    .m_sdi_valid(m_sdi_valid), .m_sdi_ready(m_sdi_ready), .m_sdi_data(m_sdi_data),
    .m_sync(m_sync), .m_sync_ready(m_sync_ready)
  );

  spi_engine_execution #(.DATA_WIDTH(DATA_WIDTH), .CLK_DIV(CLK_DIV)) u_engine (
    .clk(clk), .resetn(resetn),
    .cmd(m_cmd), .cmd_ready(m_cmd_ready),
    .sdo_valid(m_sdo_valid), .sdo_ready(m_sdo_ready), .sdo_data(m_sdo_data),
    .sdi_valid(m_sdi_valid), .sdi_ready(m_sdi_ready), .sdi_data(m_sdi_data),
    .sync(m_sync), .sync_ready(m_sync_ready),
    .cs_n(cs_n), .sclk(sclk), .sdo(sdo), .sdi(sdi)
  );

endmodule

/* spi_tb.sv */
// SPI subsystem testbench
// Drives the APB host port and the offload trigger, loops sdo back to sdi
// and checks register results, sclk edge counts and SPI timing

module spi_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import spi_cmd_pkg::*;
  import spi_cfg_pkg::*;

  localparam int DATA_WIDTH  = 8;
  localparam int CLK_DIV     = 2;
  localparam int APB_TIMEOUT = 2000;
  localparam int POLL_LIMIT  = 200;
  localparam int CS_TIMEOUT  = 500;
  // Enough reads to outlast one whole offload run of a single word
  localparam int HOLD_READS  = 20;

  typedef logic [DATA_WIDTH-1:0] word_t;

  logic     clk;
  logic     resetn;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     trigger;
  logic     cs_n;
  logic     sclk;
  logic     sdo;
  logic     sdi;

  integer   seed = 32'hc253;
  int       sclk_edges = 0;
  logic     host_hold = 1'b0;
  sync_id_t last_host_id = 8'h00;

  spi_subsystem_top #(
    .DATA_WIDTH(DATA_WIDTH),
    .CLK_DIV   (CLK_DIV)
  ) DUT (
    .clk    (clk),
    .resetn (resetn),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .trigger(trigger),
    .cs_n   (cs_n),
    .sclk   (sclk),
    .sdo    (sdo),
    .sdi    (sdi)
  );

  // Loop-back so every received word equals the word sent
  assign sdi = sdo;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Rising sclk edges seen while the slave is selected
  always @(posedge sclk) begin
    if (!cs_n) sclk_edges <= sclk_edges + 1;
  end

  // ******************************
  // Failure reporting
  // ******************************

  task automatic fail_run;
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic give_up(input string reason);
    $display("%s", reason);
    fail_run();
  endtask

  task automatic expect_equal(input string name, input apb_data_t expected,
                              input apb_data_t actual);
    assert (actual === expected)
      else begin
        $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        fail_run();
      end
  endtask

  // In mode 0 sdo may only move while sclk is low
  sdo_timing: assert property (@(posedge clk) disable iff (!resetn) $changed(sdo) |-> !sclk)
    else begin
      $display("error sdo_timing: expected sclk 0, actual 1");
      fail_run();
    end

  // A rising sclk only happens with the chip selected
  sclk_select: assert property (@(posedge clk) disable iff (!resetn) $rose(sclk) |-> !cs_n)
    else begin
      $display("error sclk_select: expected cs_n 0, actual 1");
      fail_run();
    end

  // While the host holds the engine the offload cannot clock anything
  host_exclusive: assert property (@(posedge clk) disable iff (!resetn) host_hold |-> !sclk)
    else begin
      $display("error host_exclusive: expected sclk 0, actual 1");
      fail_run();
    end

  // ******************************
  // Command words
  // ******************************

  function automatic apb_data_t cs_word(input logic level);
    return {16'd0, OP_CS, 11'd0, level};
  endfunction

  // Read and write flags both set and the count holds words minus one
  function automatic apb_data_t xfer_word(input logic [7:0] last_index);
    return {16'd0, OP_TRANSFER, 2'b00, 1'b1, 1'b1, last_index};
  endfunction

  function automatic apb_data_t sync_word(input sync_id_t id);
    return {16'd0, OP_SYNC, 4'd0, id};
  endfunction

  // ******************************
  // APB master
  // ******************************

  // Setup cycle and then access cycles until pready is seen at a falling edge
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int   waited;
    logic ready;
    waited = 0;
    ready  = 1'b0;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    while (!ready) begin
      @(negedge clk);
      if (apb_rsp.pready) ready = 1'b1;
      else if (waited < APB_TIMEOUT) waited++;
      else give_up($sformatf("APB access to 0x%0h never completed", addr));
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    logic      err;
    apb_access(1'b1, addr, data, unused, err);
    expect_equal($sformatf("pslverr_write_0x%0h", addr), 32'd0, apb_data_t'(err));
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    expect_equal($sformatf("pslverr_read_0x%0h", addr), 32'd0, apb_data_t'(err));
  endtask

  // ******************************
  // Stimulus helpers
  // ******************************

  task automatic pulse_trigger;
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
  endtask

  // Host ids avoid the offload id and the id already on record
  task automatic pick_sync_id(output sync_id_t id);
    id = sync_id_t'($random(seed));
    while (id == 8'hff || id == last_host_id) id = sync_id_t'($random(seed));
  endtask

  task automatic wait_cs_low;
    int waited;
    waited = 0;
    while (cs_n) begin
      @(negedge clk);
      if (waited < CS_TIMEOUT) waited++;
      else give_up("chip select never went low");
    end
  endtask

  // REG_SYNC is read at least once, so any id value is really looked for
  task automatic wait_sync_id(input sync_id_t id);
    apb_data_t rd;
    int        polls;
    polls = 0;
    apb_read(REG_SYNC, rd);
    while (rd[7:0] != id) begin
      if (polls < POLL_LIMIT) begin
        apb_read(REG_SYNC, rd);
        polls++;
      end else begin
        give_up($sformatf("sync id 0x%0h never showed up in REG_SYNC", id));
      end
    end
  endtask

  // Polls until bit 31 is set and then compares the low word
  task automatic wait_offload_result(input string name, input word_t expected);
    apb_data_t rd;
    int        polls;
    polls = 0;
    rd    = '0;
    while (!rd[31]) begin
      if (polls < POLL_LIMIT) begin
        apb_read(REG_OFFLOAD_RESULT, rd);
        polls++;
      end else begin
        give_up("offload result never became valid");
      end
    end
    expect_equal(name, apb_data_t'(expected), apb_data_t'(rd[DATA_WIDTH-1:0]));
  endtask

  // One host session with select, n read/write words, release and sync
  task automatic host_session(input int words, input string name);
    word_t     tx;
    apb_data_t rd;
    sync_id_t  id;
    int        start_edges;
    start_edges = sclk_edges;
    apb_write(REG_CMD, cs_word(1'b1));
    apb_write(REG_CMD, xfer_word(8'(words - 1)));
    for (int i = 0; i < words; i++) begin
      tx = word_t'($random(seed));
      apb_write(REG_SDO, apb_data_t'(tx));
      apb_read(REG_SDI, rd);
      expect_equal($sformatf("%s_sdi_%0d", name, i), apb_data_t'(tx), rd);
    end
    apb_write(REG_CMD, cs_word(1'b0));
    pick_sync_id(id);
    apb_write(REG_CMD, sync_word(id));
    // The sync is executed last, so the whole session is over once it is seen
    wait_sync_id(id);
    last_host_id = id;
    expect_equal({name, "_edges"}, apb_data_t'(words * DATA_WIDTH),
                 apb_data_t'(sclk_edges - start_edges));
    expect_equal({name, "_cs_n"}, 32'd1, apb_data_t'(cs_n));
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    apb_data_t rd;
    logic      err;
    word_t     off_word;
    sync_id_t  id;
    resetn  = 1'b0;
    apb_req = '0;
    trigger = 1'b0;

    // Reset state is checked at each falling edge while reset is held
    repeat (15) begin
      @(negedge clk);
      expect_equal("reset_cs_n", 32'd1, apb_data_t'(cs_n));
      expect_equal("reset_sclk", 32'd0, apb_data_t'(sclk));
      expect_equal("reset_sdo", 32'd0, apb_data_t'(sdo));
    end
    @(posedge clk);
    resetn <= 1'b1;
    repeat (2) @(negedge clk);
    expect_equal("after_reset_cs_n", 32'd1, apb_data_t'(cs_n));
    expect_equal("after_reset_sclk", 32'd0, apb_data_t'(sclk));
    expect_equal("after_reset_sdo", 32'd0, apb_data_t'(sdo));
    apb_read(REG_SYNC, rd);
    expect_equal("reset_sync", 32'd0, rd);

    host_session(1, "loopback");

    for (int n = 1; n <= 3; n++) begin
      host_session(n, $sformatf("edge_count_%0d", n));
    end

    // Offload run on its own
    off_word = word_t'($random(seed));
    apb_write(REG_OFFLOAD_CTRL, 32'd1);
    apb_write(REG_OFFLOAD_SDO, apb_data_t'(off_word));
    pulse_trigger();
    wait_offload_result("offload_result", off_word);

    // Offload trigger while the host keeps its session open
    off_word = word_t'($random(seed));
    apb_write(REG_OFFLOAD_SDO, apb_data_t'(off_word));
    apb_write(REG_CMD, cs_word(1'b1));
    wait_cs_low();
    host_hold = 1'b1;
    pulse_trigger();
    repeat (HOLD_READS) begin
      apb_read(REG_OFFLOAD_RESULT, rd);
      expect_equal("arbitration_hold", 32'd0, apb_data_t'(rd[31]));
    end
    host_hold = 1'b0;
    apb_write(REG_CMD, cs_word(1'b0));
    pick_sync_id(id);
    apb_write(REG_CMD, sync_word(id));
    wait_sync_id(id);
    last_host_id = id;
    wait_offload_result("arbitration_result", off_word);
    apb_read(REG_SYNC, rd);
    expect_equal("arbitration_sync", apb_data_t'(id), rd);

    // Unmapped addresses answer with an error
    apb_access(1'b0, 8'h40, 32'd0, rd, err);
    expect_equal("apb_error_read", 32'd1, apb_data_t'(err));
    apb_access(1'b1, 8'h44, 32'h1234, rd, err);
    expect_equal("apb_error_write", 32'd1, apb_data_t'(err));

    repeat (4) @(posedge clk);
    $display("Test passed");
    $finish;
  end

endmodule
